//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= conv_engine_tb
RTL_TOP   ?= conv_engine_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/conv_engine_tb.sv
`timescale 1ns/1ns

module conv_engine_tb
    import lenet_arith_pkg::*;
();

    localparam int TAPS           = 25;
    localparam int SHIFT          = 8;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int LATENCY        = 3;

    logic    clk;
    logic    reset;
    logic    in_valid;
    cmd_op_t in_op;
    data_t   in_data;
    logic    out_ready;
    logic    in_ready;
    logic    out_valid;
    data_t   out_data;
    logic    err_pixel;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (5)
    ) clock_i (
        .clk   (clk),
        .reset (reset)
    );

    conv_engine_top #(
        .KERNEL_TAPS (TAPS),
        .OUT_SHIFT   (SHIFT)
    ) conv_engine_top_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_data   (in_data),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .err_pixel (err_pixel)
    );

    //////////////////////////////////////////////////
    // Reference model and random source
    //////////////////////////////////////////////////

    logic [31:0] lfsr_state = 32'h9062;
    data_t       kernel [TAPS];
    data_t       window [TAPS];
    data_t       exp_q [$];
    int          accept_q [$];
    int          errors = 0;
    int          cycle = 0;
    int          accept_count = 0;
    int          err_count = 0;
    logic        mark_last = 1'b0;
    logic        check_latency = 1'b0;
    logic        held_valid = 1'b0;
    data_t       held_data;

    // Taps 32, 22, 2, 1.
    function automatic data_t rand_bits(input int n);
        data_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[6:0], fb};
        end
        return val;
    endfunction

    function automatic prod_t approx_product(input data_t w, input data_t p);
        logic [7:0]  pp [8];
        logic [12:0] a;
        logic [12:0] b;
        logic [12:0] c;
        logic [12:0] d;
        logic [12:0] e;
        for (int i = 0; i < 8; i++) begin
            pp[i] = p & {8{w[i]}};
        end
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        e = '0;
        a[12] = pp[4][7] & pp[5][6];
        a[11] = pp[4][6] & pp[5][5];
        a[10] = pp[2][7] & pp[3][6];
        a[9]  = pp[2][7] | pp[3][6];
        a[8]  = pp[1][7];
        a[7]  = pp[0][7] | pp[1][6];
        a[6]  = pp[2][4] | pp[3][3];
        a[4]  = pp[2][1] & pp[3][0];
        a[3]  = pp[0][3] | pp[1][2];
        a[2]  = pp[0][1] | pp[1][0];
        b[12] = pp[5][7];
        b[11] = pp[4][7] ^ pp[5][6];
        b[10] = pp[3][7];
        b[9]  = pp[4][4] & pp[5][3];
        b[8]  = pp[2][5] & pp[3][4];
        b[7]  = pp[2][5] ^ pp[3][4];
        c[10] = pp[4][5] & pp[5][4];
        c[9]  = pp[4][5] ^ pp[5][4];
        c[8]  = pp[2][6] | pp[3][5];
        c[7]  = pp[4][2] | pp[5][1];
        d[10] = pp[4][6] ^ pp[5][5];
        d[8]  = pp[4][3] | pp[5][2];
        e[8]  = pp[4][4] ^ pp[5][3];
        return prod_t'((16'(pp[6]) << 6) + (16'(pp[7]) << 7)
            + 16'(a) + 16'(b) + 16'(c) + 16'(d) + 16'(e));
    endfunction

    // Exact mode uses true products.
    function automatic data_t window_result(input logic exact);
        int sum;
        sum = 0;
        for (int i = 0; i < TAPS; i++) begin
            if (exact) begin
                sum += int'(kernel[i]) * int'(window[i]);
            end else begin
                sum += int'(approx_product(kernel[i], window[i]));
            end
        end
        sum = sum >> SHIFT;
        return (sum > 255) ? 8'd255 : data_t'(sum);
    endfunction

    //////////////////////////////////////////////////
    // Monitor and scoreboard
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle++;
        if (!reset) begin
            if (in_valid && in_ready) begin
                accept_count++;
                if (mark_last) begin
                    accept_q.push_back(cycle);
                end
            end
            if (err_pixel) begin
                err_count++;
            end
            if (held_valid) begin
                assert (out_valid && out_data == held_data) else begin
                    errors++;
                    $display("MISMATCH at %0t: stalled result changed to %0d, held %0d",
                        $time, out_data, held_data);
                end
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Error at %0t: result %0d arrived with none expected",
                        $time, out_data);
                end
                if (exp_q.size() > 0) begin
                    assert (out_data == exp_q[0]) else begin
                        errors++;
                        $display("MISMATCH at %0t: out_data %0d, expected %0d",
                            $time, out_data, exp_q[0]);
                    end
                    void'(exp_q.pop_front());
                end
                if (accept_q.size() > 0) begin
                    if (check_latency) begin
                        assert (cycle - accept_q[0] == LATENCY) else begin
                            errors++;
                            $display("MISMATCH at %0t: latency %0d cycles, expected %0d",
                                $time, cycle - accept_q[0], LATENCY);
                        end
                    end
                    void'(accept_q.pop_front());
                end
            end
            held_valid = out_valid && !out_ready;
            held_data  = out_data;
        end
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////

    // Called on a falling edge, returns on the falling edge after acceptance.
    task automatic send_cmd(input cmd_op_t op, input data_t data, input logic last);
        int target;
        in_valid  = 1'b1;
        in_op     = op;
        in_data   = data;
        mark_last = last;
        target    = accept_count + 1;
        do @(negedge clk); while (accept_count < target);
        in_valid  = 1'b0;
        mark_last = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // Mode 0 random, 1 bits 6 and 7 only, 2 all ones.
    task automatic load_kernel(input int mode);
        for (int i = 0; i < TAPS; i++) begin
            case (mode)
                1:       kernel[i] = rand_bits(2) << 6;
                2:       kernel[i] = 8'd255;
                default: kernel[i] = rand_bits(8);
            endcase
            send_cmd(OP_WEIGHT, kernel[i], 1'b0);
        end
    endtask

    // Sparse windows keep most sums below saturation.
    task automatic send_window(input logic exact, input logic full_scale);
        for (int i = 0; i < TAPS; i++) begin
            if (full_scale) begin
                window[i] = 8'd255;
            end else if (rand_bits(3) == 8'd0) begin
                window[i] = rand_bits(8);
            end else begin
                window[i] = 8'd0;
            end
        end
        exp_q.push_back(full_scale ? 8'd255 : window_result(exact));
        for (int i = 0; i < TAPS; i++) begin
            send_cmd(OP_PIXEL, window[i], i == TAPS - 1);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) @(negedge clk);
        idle(4);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_and_early_pixel();
        assert (!out_valid && !err_pixel && in_ready) else begin
            errors++;
            $display("Error at %0t: outputs not in reset state", $time);
        end
        send_cmd(OP_PIXEL, 8'h5a, 1'b0);
        idle(4);
        assert (err_count == 1) else begin
            errors++;
            $display("Error at %0t: err_pixel did not pulse once for early pixel", $time);
        end
    endtask

    task automatic test_exact_path();
        load_kernel(1);
        repeat (3) send_window(1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic test_random_windows();
        check_latency = 1'b1;
        send_cmd(OP_RESTART, 8'h00, 1'b0);
        load_kernel(0);
        repeat (4) send_window(1'b0, 1'b0);
        wait_drain();
        check_latency = 1'b0;
    endtask

    task automatic test_back_pressure();
        out_ready = 1'b0;
        fork
            repeat (3) send_window(1'b0, 1'b0);
            begin
                repeat (80) @(negedge clk);
                out_ready = 1'b1;
            end
        join
        wait_drain();
    endtask

    task automatic test_restart();
        for (int i = 0; i < 10; i++) begin
            send_cmd(OP_PIXEL, rand_bits(8), 1'b0);
        end
        send_cmd(OP_RESTART, 8'h00, 1'b0);
        load_kernel(0);
        send_window(1'b0, 1'b0);
        wait_drain();
    endtask

    task automatic test_saturation();
        send_cmd(OP_RESTART, 8'h00, 1'b0);
        load_kernel(2);
        send_window(1'b0, 1'b1);
        wait_drain();
    endtask

    initial begin
        in_valid  = 1'b0;
        in_op     = OP_WEIGHT;
        in_data   = '0;
        out_ready = 1'b1;
        @(negedge clk);
        while (reset) @(negedge clk);
        test_reset_and_early_pixel();
        test_exact_path();
        test_random_windows();
        test_back_pressure();
        test_restart();
        test_saturation();
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Error: %0d expected results never arrived", exp_q.size());
        end
        assert (err_count == 1) else begin
            errors++;
            $display("Error: err_pixel pulsed %0d times, expected once", err_count);
        end
        $display("Errors: %0d, err_pixel pulses: %0d", errors, err_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a rising edge after the hold.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- common/lenet_arith_pkg.sv
package lenet_arith_pkg;

    //////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////

    localparam int DATA_W = 8;
    localparam int PROD_W = 2 * DATA_W;

    typedef logic [DATA_W-1:0] data_t; // Pixel or weight.
    typedef logic [PROD_W-1:0] prod_t; // Approximate product.

    // Largest output pixel, the saturation ceiling.
    localparam data_t DATA_MAX = {DATA_W{1'b1}};

    //////////////////////////////////////////////////
    // Command opcodes on the input stream
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_WEIGHT  = 2'd0, // Next kernel weight.
        OP_PIXEL   = 2'd1, // Next window pixel.
        OP_RESTART = 2'd2  // Clear weight and tap counters.
    } cmd_op_t;

endpackage

//--- common/lenet_ctrl_pkg.sv
package lenet_ctrl_pkg;

    //////////////////////////////////////////////////
    // Sequencer state
    //////////////////////////////////////////////////

    typedef enum logic {
        ST_WEIGHTS = 1'b0, // Kernel still incomplete.
        ST_PIXELS  = 1'b1  // Kernel loaded, windows accepted.
    } seq_state_t;

    //////////////////////////////////////////////////
    // Width helpers
    //////////////////////////////////////////////////

    // Bits needed to index taps 0 .. taps-1, never less than one.
    function automatic int tap_idx_w(input int taps);
        if (taps > 1) begin
            return $clog2(taps);
        end
        return 1;
    endfunction

endpackage

//--- compile.f
common/lenet_arith_pkg.sv
common/lenet_ctrl_pkg.sv
verilog/approx_mult_8x8.sv
conv/kernel_store.sv
conv/mac_pipeline.sv
conv/window_sequencer.sv
verilog/conv_engine_top.sv
bench/tb_clock_gen.sv
bench/conv_engine_tb.sv

//--- conv/kernel_store.sv
`timescale 1ns/1ns

module kernel_store
    import lenet_arith_pkg::*;
    import lenet_ctrl_pkg::*;
#(
    parameter  int KERNEL_TAPS = 25,
    localparam int TAP_W       = tap_idx_w(KERNEL_TAPS)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [TAP_W-1:0] wr_addr,
    input  data_t            wr_data,
    input  logic [TAP_W-1:0] rd_addr,
    input  logic             rd_en,
    output data_t            rd_data
);

    data_t weights [KERNEL_TAPS];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                weights[i] <= '0;
            end
        end else if (wr_en) begin
            weights[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // Registered read port
    //////////////////////////////////////////////////

    // Holds its value while the pipeline is stalled.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= weights[rd_addr];
        end
    end

    // Sequencer counters must stay inside the kernel.
    assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_addr) < KERNEL_TAPS))
        else $error("kernel_store: write address out of range");

    assert property (@(posedge clk) disable iff (reset)
        rd_en |-> (int'(rd_addr) < KERNEL_TAPS))
        else $error("kernel_store: read address out of range");

endmodule

//--- conv/mac_pipeline.sv
`timescale 1ns/1ns

module mac_pipeline
    import lenet_arith_pkg::*;
    import lenet_ctrl_pkg::*;
#(
    parameter  int KERNEL_TAPS = 25,
    parameter  int OUT_SHIFT   = 8,
    localparam int ACC_W       = PROD_W + tap_idx_w(KERNEL_TAPS)
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  pix_valid,
    input  data_t pix_data,
    input  logic  pix_last, // Without pix_valid it drops the partial sum.
    input  data_t weight,
    input  logic  out_ready,
    output logic  advance,
    output logic  out_valid,
    output data_t out_data
);

    // Whole pipeline moves unless a result is stuck in the buffer.
    assign advance = !out_valid || out_ready;

    //////////////////////////////////////////////////
    // Stage 1: pixel register
    //////////////////////////////////////////////////

    logic  s1_valid;
    logic  s1_last;
    data_t s1_pix;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else if (advance) begin
            s1_valid <= pix_valid;
            s1_last  <= pix_last;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_pix <= pix_data;
        end
    end

    // Weight arrives from kernel_store in the same cycle.
    prod_t product;

    approx_mult_8x8 mult_i (
        .x (weight),
        .y (s1_pix),
        .z (product)
    );

    //////////////////////////////////////////////////
    // Stage 2: accumulator
    //////////////////////////////////////////////////

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_base;
    logic             s2_done; // acc holds a complete window.

    assign acc_base = s2_done ? '0 : acc; // Next window starts fresh.

    always_ff @(posedge clk) begin
        if (reset) begin
            acc     <= '0;
            s2_done <= 1'b0;
        end else if (advance) begin
            s2_done <= s1_valid && s1_last;
            if (s1_valid) begin
                acc <= acc_base + ACC_W'(product);
            end else if (s2_done || s1_last) begin
                acc <= '0; // Restart marker or idle after a window.
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 3: requantize and output buffer
    //////////////////////////////////////////////////

    logic [ACC_W-1:0] shifted;
    data_t            sat_data;

    assign shifted  = acc >> OUT_SHIFT;
    assign sat_data = (shifted > ACC_W'(DATA_MAX)) ? DATA_MAX : data_t'(shifted);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s2_done;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s2_done) begin
            out_data <= sat_data;
        end
    end

    // A waiting result must not change or vanish.
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("mac_pipeline: output changed while stalled");

endmodule

//--- conv/window_sequencer.sv
`timescale 1ns/1ns

module window_sequencer
    import lenet_arith_pkg::*;
    import lenet_ctrl_pkg::*;
#(
    parameter  int KERNEL_TAPS = 25,
    localparam int TAP_W       = tap_idx_w(KERNEL_TAPS)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  cmd_op_t          in_op,
    input  data_t            in_data,
    output logic             in_ready,
    input  logic             advance,
    output logic             wr_en,
    output logic [TAP_W-1:0] wr_addr,
    output data_t            wr_data,
    output logic [TAP_W-1:0] rd_addr,
    output logic             rd_en,
    output logic             pix_valid,
    output data_t            pix_data,
    output logic             pix_last,
    output logic             err_pixel
);

    localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(KERNEL_TAPS - 1);

    seq_state_t       state;
    logic [TAP_W-1:0] wt_cnt;
    logic [TAP_W-1:0] tap_cnt;

    //////////////////////////////////////////////////
    // Command decode
    //////////////////////////////////////////////////

    logic accept;
    logic is_weight;
    logic is_pixel;
    logic is_restart;

    assign in_ready   = advance;
    assign accept     = in_valid && in_ready;
    assign is_weight  = accept && (in_op == OP_WEIGHT);
    assign is_pixel   = accept && (in_op == OP_PIXEL);
    assign is_restart = accept && (in_op == OP_RESTART);

    // Weights only load while the kernel is incomplete.
    assign wr_en   = is_weight && (state == ST_WEIGHTS);
    assign wr_addr = wt_cnt;
    assign wr_data = in_data;

    assign pix_valid = is_pixel && (state == ST_PIXELS);
    assign pix_data  = in_data;
    assign rd_addr   = tap_cnt;
    assign rd_en     = pix_valid;

    // Restart goes out as a bare last flag to drop the partial sum.
    assign pix_last = (pix_valid && (tap_cnt == LAST_TAP)) || is_restart;

    //////////////////////////////////////////////////
    // State and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_WEIGHTS;
            wt_cnt    <= '0;
            tap_cnt   <= '0;
            err_pixel <= 1'b0;
        end else begin
            err_pixel <= is_pixel && (state == ST_WEIGHTS); // Pixel dropped.
            if (is_restart) begin
                state   <= ST_WEIGHTS;
                wt_cnt  <= '0;
                tap_cnt <= '0;
            end else if (wr_en) begin
                if (wt_cnt == LAST_TAP) begin
                    wt_cnt <= '0;
                    state  <= ST_PIXELS; // Kernel complete.
                end else begin
                    wt_cnt <= wt_cnt + 1'b1;
                end
            end else if (pix_valid) begin
                tap_cnt <= (tap_cnt == LAST_TAP) ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    // Pixels only flow once every weight is in.
    assert property (@(posedge clk) disable iff (reset)
        pix_valid |-> (wt_cnt == '0))
        else $error("window_sequencer: pixel issued with kernel partly loaded");

    // A stalled command must wait unchanged.
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_op) && $stable(in_data)))
        else $error("window_sequencer: input command changed while stalled");

endmodule

//--- verilog/approx_mult_8x8.sv
`timescale 1ns/1ns

module approx_mult_8x8
    import lenet_arith_pkg::*;
(
    input  data_t x, // Weight.
    input  data_t y, // Pixel.
    output prod_t z
);

    //////////////////////////////////////////////////
    // Partial products, one row per weight bit
    //////////////////////////////////////////////////

    data_t pp [8];

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    //////////////////////////////////////////////////
    // Compressed rows for weight bits 0 to 5
    //////////////////////////////////////////////////

    logic [12:0] cmp_a;
    logic [12:0] cmp_b;
    logic [12:0] cmp_c;
    logic [12:0] cmp_d;
    logic [12:0] cmp_e;

    // Listed from bit 12 down to bit 0.
    assign cmp_a = {
        pp[4][7] & pp[5][6],
        pp[4][6] & pp[5][5],
        pp[2][7] & pp[3][6],
        pp[2][7] | pp[3][6],
        pp[1][7],
        pp[0][7] | pp[1][6],
        pp[2][4] | pp[3][3],
        1'b0,
        pp[2][1] & pp[3][0],
        pp[0][3] | pp[1][2],
        pp[0][1] | pp[1][0],
        2'b00
    };

    assign cmp_b = {
        pp[5][7],
        pp[4][7] ^ pp[5][6],
        pp[3][7],
        pp[4][4] & pp[5][3],
        pp[2][5] & pp[3][4],
        pp[2][5] ^ pp[3][4],
        7'b0
    };

    assign cmp_c = {
        2'b00,
        pp[4][5] & pp[5][4],
        pp[4][5] ^ pp[5][4],
        pp[2][6] | pp[3][5],
        pp[4][2] | pp[5][1],
        7'b0
    };

    assign cmp_d = {
        2'b00,
        pp[4][6] ^ pp[5][5],
        1'b0,
        pp[4][3] | pp[5][2],
        8'b0
    };

    assign cmp_e = {
        4'b0,
        pp[4][4] ^ pp[5][3], // Lone term at bit 8.
        8'b0
    };

    //////////////////////////////////////////////////
    // Final sum
    //////////////////////////////////////////////////

    logic [15:0] row_6;
    logic [15:0] row_7;
    logic [15:0] cmp_sum;

    assign row_6 = {2'b00, pp[6], 6'b0}; // Exact rows for bits 6 and 7.
    assign row_7 = {1'b0, pp[7], 7'b0};

    assign cmp_sum = 16'(cmp_a) + 16'(cmp_b) + 16'(cmp_c) + 16'(cmp_d) + 16'(cmp_e);

    assign z = prod_t'(row_6 + row_7 + cmp_sum);

endmodule

//--- verilog/conv_engine_top.sv
`timescale 1ns/1ns

module conv_engine_top
    import lenet_arith_pkg::*;
    import lenet_ctrl_pkg::*;
#(
    parameter int KERNEL_TAPS = 25,
    parameter int OUT_SHIFT   = 8
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  cmd_op_t in_op,
    input  data_t   in_data,
    input  logic    out_ready,
    output logic    in_ready,
    output logic    out_valid,
    output data_t   out_data,
    output logic    err_pixel
);

    localparam int TAP_W = tap_idx_w(KERNEL_TAPS);

    logic             wr_en;
    logic [TAP_W-1:0] wr_addr;
    data_t            wr_data;
    logic [TAP_W-1:0] rd_addr;
    logic             rd_en;
    data_t            rd_data;
    logic             pix_valid;
    data_t            pix_data;
    logic             pix_last;
    logic             advance;

    //////////////////////////////////////////////////
    // Command decode and counters
    //////////////////////////////////////////////////

    window_sequencer #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) window_sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .advance   (advance),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_last  (pix_last),
        .err_pixel (err_pixel)
    );

    kernel_store #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) kernel_store_i (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_en   (rd_en),
        .rd_data (rd_data)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    mac_pipeline #(
        .KERNEL_TAPS (KERNEL_TAPS),
        .OUT_SHIFT   (OUT_SHIFT)
    ) mac_pipeline_i (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_last  (pix_last),
        .weight    (rd_data),
        .out_ready (out_ready),
        .advance   (advance),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule
